/* common/ret_arb_defines.svh */
`ifndef RET_ARB_DEFINES_SVH
`define RET_ARB_DEFINES_SVH

// Sizes of the return arbiter

// Parent units receiving results
`define RA_PARENT 4

// Child units returning results
`define RA_CHILD 8

// Level-1 arbitration groups
`define RA_GROUPS 2

// Children in each level-1 group, fixed
`define RA_CHILD_PER_GROUP 4

// ROB slots per parent
// Same as the number of call sequence values, so the sequence wraps on the slots
`define RA_ROB_W 4

// Result width of one child return
`define RA_RET_DW 32

`endif

/* common/ret_arb_pkg.sv */
`include "ret_arb_defines.svh"

package ret_arb_pkg;

    // Raw result from a child
    typedef logic [`RA_RET_DW-1:0]            ret_data_t;

    typedef logic [$clog2(`RA_CHILD)-1:0]     child_idx_t;   // Absolute child index
    typedef logic [$clog2(`RA_PARENT)-1:0]    parent_idx_t;  // Parent index
    typedef logic [$clog2(`RA_ROB_W)-1:0]     call_seq_t;    // Call sequence number

    // Stored word, child index above the result
    typedef logic [$bits(child_idx_t)+`RA_RET_DW-1:0] ret_word_t;

    // RAM address, parent above sequence number
    typedef logic [$bits(parent_idx_t)+$bits(call_seq_t)-1:0] ram_addr_t;

endpackage

/* source/ret_ram.sv */
`timescale 1ns/100ps
`include "ret_arb_defines.svh"

module ret_ram
    import ret_arb_pkg::*;
(
    input  logic      clk,
    input  logic      ram_we_i,
    input  ram_addr_t ram_waddr_i,
    input  ret_word_t ram_wdata_i,
    input  logic      ram_re_i,
    input  ram_addr_t ram_raddr_i,
    output ret_word_t ram_rdata_o
);

    // One word per parent and ROB slot
    ret_word_t mem [`RA_PARENT*`RA_ROB_W];

    always_ff @(posedge clk) begin
        if (ram_we_i) begin
            mem[ram_waddr_i] <= ram_wdata_i;
        end
        // Registered read, data valid the cycle after ram_re_i
        if (ram_re_i) begin
            ram_rdata_o <= mem[ram_raddr_i];
        end
    end

endmodule

/* write_path/child_ret_buffer.sv */
`timescale 1ns/100ps
`include "ret_arb_defines.svh"

module child_ret_buffer
    import ret_arb_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        child_ret_vld_i    [`RA_CHILD],
    input  ret_data_t   child_ret_data_i   [`RA_CHILD],
    input  parent_idx_t child_ret_parent_i [`RA_CHILD],
    input  call_seq_t   child_ret_seq_i    [`RA_CHILD],
    output logic        child_ret_rdy_o    [`RA_CHILD],
    input  logic        buf_take_i         [`RA_CHILD],
    output logic        buf_vld_o          [`RA_CHILD],
    output ret_data_t   buf_data_o         [`RA_CHILD],
    output parent_idx_t buf_parent_o       [`RA_CHILD],
    output call_seq_t   buf_seq_o          [`RA_CHILD]
);

    always_comb begin
        for (int c = 0; c < `RA_CHILD; c++) begin
            child_ret_rdy_o[c] = !buf_vld_o[c];  // Ready only while the entry is empty
        end
    end

    // Entry state, a full entry only leaves on its grant
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_vld_o <= '{default: 1'b0};
        end else begin
            for (int c = 0; c < `RA_CHILD; c++) begin
                if (buf_take_i[c]) begin
                    buf_vld_o[c] <= 1'b0;
                end else if (child_ret_vld_i[c] && !buf_vld_o[c]) begin
                    buf_vld_o[c] <= 1'b1;  // Accept edge
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < `RA_CHILD; c++) begin
            if (child_ret_vld_i[c] && !buf_vld_o[c]) begin
                buf_data_o[c]   <= child_ret_data_i[c];
                buf_parent_o[c] <= child_ret_parent_i[c];
                buf_seq_o[c]    <= child_ret_seq_i[c];
            end
        end
    end

    // Level-1 grant must only take an occupied entry
    for (genvar c = 0; c < `RA_CHILD; c++) begin : g_chk
        a_take_full: assert property (@(posedge clk) disable iff (!rstn)
            buf_take_i[c] |-> buf_vld_o[c])
            else $error("child %0d granted with empty buffer", c);
    end

endmodule

/* write_path/group_arbiter.sv */
`timescale 1ns/100ps
`include "ret_arb_defines.svh"

module group_arbiter
    import ret_arb_pkg::*;
#(
    parameter int GROUP_BASE = 0  // Absolute index of the group's first child
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        buf_vld_i    [`RA_CHILD_PER_GROUP],
    input  ret_data_t   buf_data_i   [`RA_CHILD_PER_GROUP],
    input  parent_idx_t buf_parent_i [`RA_CHILD_PER_GROUP],
    input  call_seq_t   buf_seq_i    [`RA_CHILD_PER_GROUP],
    output logic        buf_take_o   [`RA_CHILD_PER_GROUP],
    input  logic        l1_clr_i,
    output logic        l1_vld_o,
    output child_idx_t  l1_child_o,
    output parent_idx_t l1_parent_o,
    output ret_data_t   l1_data_o,
    output call_seq_t   l1_seq_o
);

    typedef logic [$clog2(`RA_CHILD_PER_GROUP)-1:0] lidx_t;  // Index inside the group

    lidx_t rr_ptr;    // Search starts here, one past the last grant
    lidx_t cand;
    lidx_t sel;
    logic  hit;
    logic  can_load;  // Register empty or leaving this cycle

    assign can_load = !l1_vld_o || l1_clr_i;

    // First valid buffer at or after the pointer
    always_comb begin
        hit  = 1'b0;
        sel  = rr_ptr;
        cand = rr_ptr;
        for (int i = 0; i < `RA_CHILD_PER_GROUP; i++) begin
            cand = rr_ptr + lidx_t'(i);  // Wraps on the group size
            if (!hit && buf_vld_i[cand]) begin
                hit = 1'b1;
                sel = cand;
            end
        end
        for (int c = 0; c < `RA_CHILD_PER_GROUP; c++) begin
            buf_take_o[c] = can_load && hit && (sel == lidx_t'(c));  // Grant pulse
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            l1_vld_o <= 1'b0;
            rr_ptr   <= '0;
        end else if (can_load) begin
            l1_vld_o <= hit;  // Drops when cleared with nothing waiting
            if (hit) begin
                rr_ptr <= sel + lidx_t'(1);
            end
        end
    end

    // Group register payload
    always_ff @(posedge clk) begin
        if (can_load && hit) begin
            l1_child_o  <= child_idx_t'(GROUP_BASE) + child_idx_t'(sel);
            l1_parent_o <= buf_parent_i[sel];
            l1_data_o   <= buf_data_i[sel];
            l1_seq_o    <= buf_seq_i[sel];
        end
    end

endmodule

/* write_path/ram_write_arbiter.sv */
`timescale 1ns/100ps
`include "ret_arb_defines.svh"

module ram_write_arbiter
    import ret_arb_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        l1_vld_i    [`RA_GROUPS],
    input  child_idx_t  l1_child_i  [`RA_GROUPS],
    input  parent_idx_t l1_parent_i [`RA_GROUPS],
    input  ret_data_t   l1_data_i   [`RA_GROUPS],
    input  call_seq_t   l1_seq_i    [`RA_GROUPS],
    output logic        l1_clr_o    [`RA_GROUPS],
    output logic        ram_we_o,
    output ram_addr_t   ram_waddr_o,
    output ret_word_t   ram_wdata_o
);

    typedef logic [$clog2(`RA_GROUPS)-1:0] grp_idx_t;

    grp_idx_t grp_ptr;  // Group with priority this cycle
    grp_idx_t cand;
    grp_idx_t sel;

    // Same-cycle pick, write and clear share one edge
    always_comb begin
        ram_we_o = 1'b0;
        sel      = grp_ptr;
        cand     = grp_ptr;
        for (int i = 0; i < `RA_GROUPS; i++) begin
            cand = grp_ptr + grp_idx_t'(i);
            if (!ram_we_o && l1_vld_i[cand]) begin
                ram_we_o = 1'b1;
                sel      = cand;
            end
        end
        for (int g = 0; g < `RA_GROUPS; g++) begin
            l1_clr_o[g] = ram_we_o && (sel == grp_idx_t'(g));
        end
        ram_waddr_o = {l1_parent_i[sel], l1_seq_i[sel]};  // Slot of this call
        ram_wdata_o = {l1_child_i[sel], l1_data_i[sel]};
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            grp_ptr <= '0;
        end else if (ram_we_o) begin
            grp_ptr <= sel + grp_idx_t'(1);
        end
    end

endmodule

/* read_path/rob_reader.sv */
`timescale 1ns/100ps
`include "ret_arb_defines.svh"

module rob_reader
    import ret_arb_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      ram_we_i,
    input  ram_addr_t ram_waddr_i,
    output logic      ram_re_o,
    output ram_addr_t ram_raddr_o,
    input  ret_word_t ram_rdata_i,
    input  logic      parent_ret_pop_i  [`RA_PARENT],
    output logic      parent_ret_vld_o  [`RA_PARENT],
    output ret_word_t parent_ret_word_o [`RA_PARENT]
);

    localparam int SLOTS = `RA_PARENT * `RA_ROB_W;
    typedef logic [SLOTS-1:0] slot_map_t;

    slot_map_t              rob_vld;               // One bit per RAM word, indexed by address
    call_seq_t              pop_seq [`RA_PARENT];  // Next sequence each parent expects
    logic [`RA_PARENT-1:0]  inflight;              // Read issued, output not yet filled
    parent_idx_t            rr_ptr;
    parent_idx_t            cand;
    parent_idx_t            rd_par;
    logic                   rd_go;
    ram_addr_t              rd_addr;
    logic                   rdat_vld_q;  // ram_rdata_i holds a word this cycle
    parent_idx_t            rdat_par_q;

    // Round robin over parents ready for their next word
    always_comb begin
        rd_go  = 1'b0;
        rd_par = rr_ptr;
        cand   = rr_ptr;
        for (int i = 0; i < `RA_PARENT; i++) begin
            cand = rr_ptr + parent_idx_t'(i);
            if (!rd_go && rob_vld[{cand, pop_seq[cand]}] &&
                !parent_ret_vld_o[cand] && !inflight[cand]) begin
                rd_go  = 1'b1;
                rd_par = cand;
            end
        end
    end

    assign rd_addr = {rd_par, pop_seq[rd_par]};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rob_vld          <= '0;
            pop_seq          <= '{default: '0};
            inflight         <= '0;
            rr_ptr           <= '0;
            ram_re_o         <= 1'b0;
            rdat_vld_q       <= 1'b0;
            parent_ret_vld_o <= '{default: 1'b0};
        end else begin
            ram_re_o   <= rd_go;     // Read issues on the edge after the pick
            rdat_vld_q <= ram_re_o;  // RAM data one cycle later
            if (rd_go) begin
                rob_vld[rd_addr] <= 1'b0;
                pop_seq[rd_par]  <= pop_seq[rd_par] + call_seq_t'(1);
                rr_ptr           <= rd_par + parent_idx_t'(1);
            end
            if (ram_we_i) begin
                rob_vld[ram_waddr_i] <= 1'b1;  // Never the slot being read
            end
            for (int p = 0; p < `RA_PARENT; p++) begin
                if (rdat_vld_q && (rdat_par_q == parent_idx_t'(p))) begin
                    parent_ret_vld_o[p] <= 1'b1;
                    inflight[p]         <= 1'b0;
                end else begin
                    if (parent_ret_pop_i[p]) parent_ret_vld_o[p] <= 1'b0;  // Pop on empty is a no-op
                    if (rd_go && (rd_par == parent_idx_t'(p))) inflight[p] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) ram_raddr_o <= rd_addr;
        if (ram_re_o) rdat_par_q <= parent_idx_t'(ram_raddr_o >> $bits(call_seq_t));
        for (int p = 0; p < `RA_PARENT; p++) begin
            if (rdat_vld_q && (rdat_par_q == parent_idx_t'(p))) begin
                parent_ret_word_o[p] <= ram_rdata_i;
            end
        end
    end

    // More than ROB_W calls outstanding on a parent would land here
    a_wr_free: assert property (@(posedge clk) disable iff (!rstn)
        ram_we_i |-> !rob_vld[ram_waddr_i])
        else $error("return written to occupied ROB slot %0d", ram_waddr_i);

    a_rd_set: assert property (@(posedge clk) disable iff (!rstn)
        ram_re_o |-> |($past(rob_vld) & (slot_map_t'(1) << ram_raddr_o)))
        else $error("RAM read of empty ROB slot %0d", ram_raddr_o);

    a_no_overwrite: assert property (@(posedge clk) disable iff (!rstn)
        rdat_vld_q |-> !parent_ret_vld_o[rdat_par_q])
        else $error("output buffer of parent %0d overwritten", rdat_par_q);

endmodule

/* source/return_arbiter.sv */
`timescale 1ns/100ps
`include "ret_arb_defines.svh"

module return_arbiter
    import ret_arb_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        child_ret_vld_i    [`RA_CHILD],
    input  ret_data_t   child_ret_data_i   [`RA_CHILD],
    input  parent_idx_t child_ret_parent_i [`RA_CHILD],
    input  call_seq_t   child_ret_seq_i    [`RA_CHILD],
    output logic        child_ret_rdy_o    [`RA_CHILD],
    input  logic        parent_ret_pop_i   [`RA_PARENT],
    output logic        parent_ret_vld_o   [`RA_PARENT],
    output ret_word_t   parent_ret_word_o  [`RA_PARENT]
);

    // Child input buffers
    logic        buf_vld    [`RA_CHILD];
    ret_data_t   buf_data   [`RA_CHILD];
    parent_idx_t buf_parent [`RA_CHILD];
    call_seq_t   buf_seq    [`RA_CHILD];
    logic        grp_take   [`RA_CHILD];

    // Level-1 group registers
    logic        l1_vld    [`RA_GROUPS];
    child_idx_t  l1_child  [`RA_GROUPS];
    parent_idx_t l1_parent [`RA_GROUPS];
    ret_data_t   l1_data   [`RA_GROUPS];
    call_seq_t   l1_seq    [`RA_GROUPS];
    logic        l1_clr    [`RA_GROUPS];

    logic      ram_we;
    ram_addr_t ram_waddr;
    ret_word_t ram_wdata;
    logic      ram_re;
    ram_addr_t ram_raddr;
    ret_word_t ram_rdata;

    child_ret_buffer u_child_ret_buffer (
        .clk                (clk),
        .rstn               (rstn),
        .child_ret_vld_i    (child_ret_vld_i),
        .child_ret_data_i   (child_ret_data_i),
        .child_ret_parent_i (child_ret_parent_i),
        .child_ret_seq_i    (child_ret_seq_i),
        .child_ret_rdy_o    (child_ret_rdy_o),
        .buf_take_i         (grp_take),
        .buf_vld_o          (buf_vld),
        .buf_data_o         (buf_data),
        .buf_parent_o       (buf_parent),
        .buf_seq_o          (buf_seq)
    );

    // Children 0 to 3
    group_arbiter #(.GROUP_BASE(0)) u_group0 (
        .clk          (clk),
        .rstn         (rstn),
        .buf_vld_i    (buf_vld[0:`RA_CHILD_PER_GROUP-1]),
        .buf_data_i   (buf_data[0:`RA_CHILD_PER_GROUP-1]),
        .buf_parent_i (buf_parent[0:`RA_CHILD_PER_GROUP-1]),
        .buf_seq_i    (buf_seq[0:`RA_CHILD_PER_GROUP-1]),
        .buf_take_o   (grp_take[0:`RA_CHILD_PER_GROUP-1]),
        .l1_clr_i     (l1_clr[0]),
        .l1_vld_o     (l1_vld[0]),
        .l1_child_o   (l1_child[0]),
        .l1_parent_o  (l1_parent[0]),
        .l1_data_o    (l1_data[0]),
        .l1_seq_o     (l1_seq[0])
    );

    // Children 4 to 7
    group_arbiter #(.GROUP_BASE(4)) u_group1 (
        .clk          (clk),
        .rstn         (rstn),
        .buf_vld_i    (buf_vld[`RA_CHILD_PER_GROUP:`RA_CHILD-1]),
        .buf_data_i   (buf_data[`RA_CHILD_PER_GROUP:`RA_CHILD-1]),
        .buf_parent_i (buf_parent[`RA_CHILD_PER_GROUP:`RA_CHILD-1]),
        .buf_seq_i    (buf_seq[`RA_CHILD_PER_GROUP:`RA_CHILD-1]),
        .buf_take_o   (grp_take[`RA_CHILD_PER_GROUP:`RA_CHILD-1]),
        .l1_clr_i     (l1_clr[1]),
        .l1_vld_o     (l1_vld[1]),
        .l1_child_o   (l1_child[1]),
        .l1_parent_o  (l1_parent[1]),
        .l1_data_o    (l1_data[1]),
        .l1_seq_o     (l1_seq[1])
    );

    ram_write_arbiter u_ram_write_arbiter (
        .clk         (clk),
        .rstn        (rstn),
        .l1_vld_i    (l1_vld),
        .l1_child_i  (l1_child),
        .l1_parent_i (l1_parent),
        .l1_data_i   (l1_data),
        .l1_seq_i    (l1_seq),
        .l1_clr_o    (l1_clr),
        .ram_we_o    (ram_we),
        .ram_waddr_o (ram_waddr),
        .ram_wdata_o (ram_wdata)
    );

    ret_ram u_ret_ram (
        .clk         (clk),
        .ram_we_i    (ram_we),
        .ram_waddr_i (ram_waddr),
        .ram_wdata_i (ram_wdata),
        .ram_re_i    (ram_re),
        .ram_raddr_i (ram_raddr),
        .ram_rdata_o (ram_rdata)
    );

    // ROB bitmap follows the RAM write port
    rob_reader u_rob_reader (
        .clk               (clk),
        .rstn              (rstn),
        .ram_we_i          (ram_we),
        .ram_waddr_i       (ram_waddr),
        .ram_re_o          (ram_re),
        .ram_raddr_o       (ram_raddr),
        .ram_rdata_i       (ram_rdata),
        .parent_ret_pop_i  (parent_ret_pop_i),
        .parent_ret_vld_o  (parent_ret_vld_o),
        .parent_ret_word_o (parent_ret_word_o)
    );

endmodule

/* dv/return_arbiter_tb.sv */
`timescale 1ns/100ps
`include "ret_arb_defines.svh"

module return_arbiter_tb
    import ret_arb_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;  // Random, stall and full-load phases take ~1500

    logic        clk;
    logic        rstn;
    logic        child_ret_vld_i    [`RA_CHILD];
    ret_data_t   child_ret_data_i   [`RA_CHILD];
    parent_idx_t child_ret_parent_i [`RA_CHILD];
    call_seq_t   child_ret_seq_i    [`RA_CHILD];
    logic        child_ret_rdy_o    [`RA_CHILD];
    logic        parent_ret_pop_i   [`RA_PARENT];
    logic        parent_ret_vld_o   [`RA_PARENT];
    ret_word_t   parent_ret_word_o  [`RA_PARENT];

    // Scoreboard, expected word per parent and call sequence
    ret_word_t exp_word  [`RA_PARENT][`RA_ROB_W];
    call_seq_t iss_seq   [`RA_PARENT];  // Next sequence to issue
    call_seq_t exp_seq   [`RA_PARENT];  // Next sequence to pop
    int        out_cnt   [`RA_PARENT];  // Issued and not yet popped
    logic      held      [`RA_PARENT];  // Valid without pop at the last sample
    ret_word_t held_word [`RA_PARENT];
    logic      busy      [`RA_CHILD];   // Child owns a call
    logic      taken     [`RA_CHILD];   // Return accepted at the coming edge
    int        ret_delay [`RA_CHILD];
    int        cycle_cnt = 0;
    int        other_pops = 0;
    int        stall_par = -1;         // Parent withholding pop, -1 for none
    logic      issue_on = 1'b0;
    string     test_name = "reset";

    return_arbiter u_return_arbiter (
        .clk                (clk),
        .rstn               (rstn),
        .child_ret_vld_i    (child_ret_vld_i),
        .child_ret_data_i   (child_ret_data_i),
        .child_ret_parent_i (child_ret_parent_i),
        .child_ret_seq_i    (child_ret_seq_i),
        .child_ret_rdy_o    (child_ret_rdy_o),
        .parent_ret_pop_i   (parent_ret_pop_i),
        .parent_ret_vld_o   (parent_ret_vld_o),
        .parent_ret_word_o  (parent_ret_word_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    task automatic fail_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    function automatic logic drained();
        logic d = 1'b1;
        for (int p = 0; p < `RA_PARENT; p++) begin
            if (out_cnt[p] != 0) d = 1'b0;
        end
        return d;
    endfunction

    // Outputs that should be quiet once every call is popped
    function automatic int active_outputs();
        int n = 0;
        for (int p = 0; p < `RA_PARENT; p++) begin
            if (parent_ret_vld_o[p]) n++;
        end
        for (int c = 0; c < `RA_CHILD; c++) begin
            if (!child_ret_rdy_o[c]) n++;
        end
        return n;
    endfunction

    task automatic check_reset_outputs();
        for (int p = 0; p < `RA_PARENT; p++) begin
            assert (!parent_ret_vld_o[p]) else begin
                $display("error test %s parent %0d valid expected 0 actual 1", test_name, p);
                fail_run();
            end
        end
        for (int c = 0; c < `RA_CHILD; c++) begin
            assert (child_ret_rdy_o[c]) else begin
                $display("error test %s child %0d ready expected 1 actual 0", test_name, c);
                fail_run();
            end
        end
    endtask

    // Falling edge view of what the next rising edge will do
    task automatic sample_outputs();
        ret_word_t want;
        for (int p = 0; p < `RA_PARENT; p++) begin
            if (held[p]) begin
                // Stalled parent keeps its word
                assert (parent_ret_vld_o[p] && parent_ret_word_o[p] == held_word[p]) else begin
                    $display("error test %s parent %0d held word expected %h actual %h vld %0b",
                             test_name, p, held_word[p], parent_ret_word_o[p],
                             parent_ret_vld_o[p]);
                    fail_run();
                end
            end
            if (parent_ret_vld_o[p] && parent_ret_pop_i[p]) begin
                assert (out_cnt[p] > 0) else begin
                    $display("Parent %0d delivered a word with no call outstanding", p);
                    fail_run();
                end
                want = exp_word[p][exp_seq[p]];  // Oldest call of this parent
                assert (parent_ret_word_o[p] == want) else begin
                    $display("error test %s parent %0d seq %0d expected %h actual %h",
                             test_name, p, exp_seq[p], want, parent_ret_word_o[p]);
                    fail_run();
                end
                exp_seq[p] = exp_seq[p] + call_seq_t'(1);
                out_cnt[p]--;
                if (stall_par >= 0 && p != stall_par) other_pops++;
            end
            held[p]      = parent_ret_vld_o[p] && !parent_ret_pop_i[p];
            held_word[p] = parent_ret_word_o[p];
        end
        for (int c = 0; c < `RA_CHILD; c++) begin
            taken[c] = child_ret_vld_i[c] && child_ret_rdy_o[c];
        end
    endtask

    task automatic assign_call(int c, int p, int d);
        ret_data_t data;
        data                  = $urandom;
        busy[c]               = 1'b1;
        ret_delay[c]          = d;  // Cycles before the child returns
        child_ret_data_i[c]   = data;
        child_ret_parent_i[c] = parent_idx_t'(p);
        child_ret_seq_i[c]    = iss_seq[p];
        exp_word[p][iss_seq[p]] = {child_idx_t'(c), data};
        iss_seq[p] = iss_seq[p] + call_seq_t'(1);
        out_cnt[p]++;
    endtask

    task automatic drive_inputs();
        int c;
        for (int k = 0; k < `RA_CHILD; k++) begin
            if (taken[k]) begin
                busy[k]            = 1'b0;
                child_ret_vld_i[k] = 1'b0;
            end else if (busy[k] && !child_ret_vld_i[k]) begin
                if (ret_delay[k] == 0) child_ret_vld_i[k] = 1'b1;
                else ret_delay[k]--;
            end
        end
        for (int p = 0; p < `RA_PARENT; p++) begin
            // Four outstanding calls at most, counted until the pop
            if (issue_on && out_cnt[p] < `RA_ROB_W && $urandom_range(1, 0) == 1) begin
                c = $urandom_range(`RA_CHILD - 1, 0);
                for (int i = 0; i < `RA_CHILD && busy[c]; i++) c = (c + 1) % `RA_CHILD;
                if (!busy[c]) assign_call(c, p, $urandom_range(12, 0));
            end
            parent_ret_pop_i[p] = (p != stall_par) && ($urandom_range(3, 0) != 0);
        end
    endtask

    // All eight children return together, parents mixed
    task automatic load_all_children();
        int p;
        for (int c = 0; c < `RA_CHILD; c++) begin
            p = $urandom_range(`RA_PARENT - 1, 0);
            while (out_cnt[p] >= `RA_ROB_W) p = (p + 1) % `RA_PARENT;
            assign_call(c, p, 1);
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        sample_outputs();
        @(posedge clk);
        #2;
        drive_inputs();
    endtask

    task automatic wait_drained();
        while (!drained()) step_cycle();
    endtask

    initial begin
        void'($urandom(32'hd8602f69));
        rstn = 1'b0;
        for (int c = 0; c < `RA_CHILD; c++) begin
            child_ret_vld_i[c]    = 1'b0;
            child_ret_data_i[c]   = '0;
            child_ret_parent_i[c] = '0;
            child_ret_seq_i[c]    = '0;
            busy[c]               = 1'b0;
            taken[c]              = 1'b0;
            ret_delay[c]          = 0;
        end
        for (int p = 0; p < `RA_PARENT; p++) begin
            parent_ret_pop_i[p] = 1'b0;
            iss_seq[p]          = '0;
            exp_seq[p]          = '0;
            out_cnt[p]          = 0;
            held[p]             = 1'b0;
            held_word[p]        = '0;
        end
        repeat (5) begin
            @(negedge clk);
            check_reset_outputs();
        end
        @(posedge clk);
        #2;
        rstn = 1'b1;
        @(negedge clk);
        check_reset_outputs();  // First cycle out of reset

        test_name = "random";
        issue_on  = 1'b1;
        repeat (400) step_cycle();

        test_name = "stall";
        for (int s = 0; s < 3; s++) begin
            stall_par  = $urandom_range(`RA_PARENT - 1, 0);
            other_pops = 0;
            repeat (60) step_cycle();
            assert (other_pops > 0) else begin
                $display("Other parents got no words while parent %0d stalled", stall_par);
                fail_run();
            end
            stall_par = -1;
            repeat (20) step_cycle();
        end

        test_name = "full_load";
        issue_on  = 1'b0;
        for (int r = 0; r < 25; r++) begin
            wait_drained();
            step_cycle();
            load_all_children();
        end
        wait_drained();
        repeat (10) step_cycle();  // No stray word may show up once drained

        if (active_outputs() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("error test %s active outputs after drain expected 0 actual %0d",
                     test_name, active_outputs());
            fail_run();
        end
    end

endmodule

/* return_arbiter.f */
+incdir+common
common/ret_arb_pkg.sv
source/ret_ram.sv
write_path/child_ret_buffer.sv
write_path/group_arbiter.sv
write_path/ram_write_arbiter.sv
read_path/rob_reader.sv
source/return_arbiter.sv
dv/return_arbiter_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the return arbiter testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module return_arbiter_tb -f return_arbiter.f \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vreturn_arbiter_tb 2>&1 | tee sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || grep -q "All tests passed" sim.log && echo "Simulation PASSED" \
    || { echo "Simulation ended without a result"; exit 1; }
